// ==== logic/llc_pkg.sv ====
package llc_pkg;

    // directory geometry
    localparam int llc_ways     = 4;
    localparam int llc_way_bits = 2;
    localparam int llc_sets     = 16;
    localparam int llc_set_bits = 4;
    localparam int llc_tag_bits = 8;

    // bus side
    localparam int llc_bus_data_bits = 32;

    // word addresses on the slave port
    localparam logic llc_addr_req    = 1'b0;
    localparam logic llc_addr_result = 1'b1;

    typedef logic [llc_tag_bits-1:0] llc_tag_t;
    typedef logic [llc_way_bits-1:0] llc_way_t;
    typedef logic [llc_set_bits-1:0] llc_set_t;

    // SD lines are never picked as a victim while anything else is available
    typedef enum logic [1:0] {
        INVALID = 2'd0,
        VALID   = 2'd1,
        SHARED  = 2'd2,
        SD      = 2'd3
    } llc_state_t;

    // lookup request, low 14 bits of the write data
    typedef struct packed {
        llc_set_t   set;
        llc_tag_t   tag;
        llc_state_t new_state;
    } llc_req_t;

    // lookup result, low 14 bits of the read data
    typedef struct packed {
        logic       hit;
        logic       evict;
        llc_way_t   way;
        llc_tag_t   old_tag;
        llc_state_t old_state;
    } llc_result_t;

    // one set as read out of the store
    typedef struct packed {
        llc_tag_t   [llc_ways-1:0] tags;
        llc_state_t [llc_ways-1:0] states;
        llc_way_t                  evict_ptr;
    } llc_set_buf_t;

endpackage

// ==== logic/llc_tag_store.sv ====
`timescale 1ns/1ps

module llc_tag_store (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 rd_en,
    input  llc_pkg::llc_set_t    rd_set,
    output llc_pkg::llc_set_buf_t set_buf,
    input  logic                 wr_en,
    input  llc_pkg::llc_set_t    wr_set,
    input  llc_pkg::llc_way_t    wr_way,
    input  llc_pkg::llc_tag_t    wr_tag,
    input  llc_pkg::llc_state_t  wr_state,
    input  logic                 ptr_en,
    input  llc_pkg::llc_way_t    ptr_next
);

    llc_pkg::llc_tag_t   [llc_pkg::llc_ways-1:0] tag_mem   [llc_pkg::llc_sets];
    llc_pkg::llc_state_t [llc_pkg::llc_ways-1:0] state_mem [llc_pkg::llc_sets];
    llc_pkg::llc_way_t                           ptr_mem   [llc_pkg::llc_sets];

    // an empty way reports old tag zero
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            for (int s = 0; s < llc_pkg::llc_sets; s++) begin
                tag_mem[s] <= '0;
            end
        end else if (wr_en) begin
            tag_mem[wr_set][wr_way] <= wr_tag;
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            for (int s = 0; s < llc_pkg::llc_sets; s++) begin
                for (int w = 0; w < llc_pkg::llc_ways; w++) begin
                    state_mem[s][w] <= llc_pkg::INVALID;
                end
            end
        end else if (wr_en) begin
            state_mem[wr_set][wr_way] <= wr_state;
        end
    end

    // eviction pointer only moves after a victim was taken
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            for (int s = 0; s < llc_pkg::llc_sets; s++) begin
                ptr_mem[s] <= '0;
            end
        end else if (ptr_en) begin
            ptr_mem[wr_set] <= ptr_next;
        end
    end

    // whole set image, valid the cycle after rd_en
    always_ff @(posedge clk) begin
        if (rd_en) begin
            set_buf.tags      <= tag_mem[rd_set];
            set_buf.states    <= state_mem[rd_set];
            set_buf.evict_ptr <= ptr_mem[rd_set];
        end
    end

endmodule

// ==== logic/llc_lookup_way.sv ====
`timescale 1ns/1ps

module llc_lookup_way (
    input  logic                  clk,
    input  logic                  rst,
    input  llc_pkg::llc_tag_t     tag,
    input  llc_pkg::llc_set_buf_t set_buf,
    input  logic                  lookup_en,
    output llc_pkg::llc_way_t     way,
    output llc_pkg::llc_way_t     way_next,
    output logic                  evict
);

    logic [llc_pkg::llc_ways-1:0] hit_vec;
    logic [llc_pkg::llc_ways-1:0] empty_vec;
    logic [llc_pkg::llc_ways-1:0] valid_vec;
    logic [llc_pkg::llc_ways-1:0] not_sd_vec;
    llc_pkg::llc_way_t rot_way;
    llc_pkg::llc_way_t hit_way;
    llc_pkg::llc_way_t empty_way;
    llc_pkg::llc_way_t valid_ofs;
    llc_pkg::llc_way_t not_sd_ofs;
    logic evict_next;

    // victim vectors are indexed by distance from the pointer
    always_comb begin
        rot_way = '0;
        for (int i = 0; i < llc_pkg::llc_ways; i++) begin
            hit_vec[i]   = (set_buf.tags[i] == tag) &&
                           (set_buf.states[i] != llc_pkg::INVALID);
            empty_vec[i] = (set_buf.states[i] == llc_pkg::INVALID);
            rot_way       = llc_pkg::llc_way_t'(i) + set_buf.evict_ptr;
            valid_vec[i]  = (set_buf.states[rot_way] == llc_pkg::VALID);
            not_sd_vec[i] = (set_buf.states[rot_way] != llc_pkg::SD);
        end
    end

    // walk downward so the lowest set bit wins
    always_comb begin
        hit_way    = '0;
        empty_way  = '0;
        valid_ofs  = '0;
        not_sd_ofs = '0;
        for (int j = llc_pkg::llc_ways - 1; j >= 0; j--) begin
            if (hit_vec[j]) begin
                hit_way = llc_pkg::llc_way_t'(j);
            end
            if (empty_vec[j]) begin
                empty_way = llc_pkg::llc_way_t'(j);
            end
            if (valid_vec[j]) begin
                valid_ofs = llc_pkg::llc_way_t'(j);
            end
            if (not_sd_vec[j]) begin
                not_sd_ofs = llc_pkg::llc_way_t'(j);
            end
        end
    end

    always_comb begin
        evict_next = 1'b1;
        if (|hit_vec) begin
            way_next   = hit_way;
            evict_next = 1'b0;
        end else if (|empty_vec) begin
            way_next   = empty_way;
            evict_next = 1'b0;
        end else if (|valid_vec) begin
            way_next = valid_ofs + set_buf.evict_ptr;
        end else if (|not_sd_vec) begin
            way_next = not_sd_ofs + set_buf.evict_ptr;
        end else begin
            way_next = set_buf.evict_ptr;
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            way   <= '0;
            evict <= 1'b0;
        end else if (lookup_en) begin
            way   <= way_next;
            evict <= evict_next;
        end
    end

endmodule

// ==== logic/llc_lookup_ctrl.sv ====
`timescale 1ns/1ps

module llc_lookup_ctrl (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                wb_cyc,
    input  logic                                wb_stb,
    input  logic                                wb_we,
    input  logic                                wb_adr,
    input  logic [llc_pkg::llc_bus_data_bits-1:0] wb_dat_w,
    output logic [llc_pkg::llc_bus_data_bits-1:0] wb_dat_r,
    output logic                                wb_ack,
    output logic                                rd_en,
    output llc_pkg::llc_set_t                   rd_set,
    input  llc_pkg::llc_set_buf_t               set_buf,
    output logic                                lookup_en,
    input  llc_pkg::llc_way_t                   way,
    input  logic                                evict,
    output logic                                wr_en,
    output llc_pkg::llc_set_t                   wr_set,
    output llc_pkg::llc_way_t                   wr_way,
    output llc_pkg::llc_tag_t                   wr_tag,
    output llc_pkg::llc_state_t                 wr_state,
    output logic                                ptr_en,
    output llc_pkg::llc_way_t                   ptr_next
);

    localparam int req_bits = $bits(llc_pkg::llc_req_t);
    localparam int pad_bits = llc_pkg::llc_bus_data_bits - $bits(llc_pkg::llc_result_t);

    typedef enum logic [2:0] {
        st_idle,
        st_read,
        st_lookup,
        st_update,
        st_ack
    } ctrl_state_t;

    ctrl_state_t          state;
    ctrl_state_t          state_next;
    llc_pkg::llc_req_t    req_q;
    llc_pkg::llc_result_t result_q;
    llc_pkg::llc_result_t result_next;
    logic                 strobe;
    logic                 req_write;

    assign strobe    = wb_cyc && wb_stb;
    assign req_write = wb_we && (wb_adr == llc_pkg::llc_addr_req);

    // a request write runs the full sequence, everything else acks next cycle
    always_comb begin
        state_next = state;
        case (state)
            st_idle: begin
                if (strobe) begin
                    if (req_write) begin
                        state_next = st_read;
                    end else begin
                        state_next = st_ack;
                    end
                end
            end
            st_read: begin
                state_next = st_lookup;
            end
            st_lookup: begin
                state_next = st_update;
            end
            st_update: begin
                state_next = st_ack;
            end
            default: begin
                state_next = st_idle;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state <= st_idle;
        end else begin
            state <= state_next;
        end
    end

    always_ff @(posedge clk) begin
        if (state == st_idle && strobe && req_write) begin
            req_q <= llc_pkg::llc_req_t'(wb_dat_w[req_bits-1:0]);
        end
    end

    // victim details come from the buffered set at the registered way
    always_comb begin
        result_next.hit       = (set_buf.tags[way] == req_q.tag) &&
                                (set_buf.states[way] != llc_pkg::INVALID);
        result_next.evict     = evict;
        result_next.way       = way;
        result_next.old_tag   = set_buf.tags[way];
        result_next.old_state = set_buf.states[way];
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            result_q <= '0;
        end else if (state == st_update) begin
            result_q <= result_next;
        end
    end

    assign rd_en     = (state == st_read);
    assign rd_set    = req_q.set;
    assign lookup_en = (state == st_lookup);

    assign wr_en    = (state == st_update);
    assign wr_set   = req_q.set;
    assign wr_way   = way;
    assign wr_tag   = req_q.tag;
    assign wr_state = req_q.new_state;

    // pointer steps one past the victim, wrapping at the way count
    assign ptr_en   = (state == st_update) && evict;
    assign ptr_next = way + 1'b1;

    assign wb_ack   = (state == st_ack);
    assign wb_dat_r = (wb_adr == llc_pkg::llc_addr_result) ?
                      {{pad_bits{1'b0}}, result_q} : '0;

endmodule

// ==== logic/llc_lookup_top.sv ====
`timescale 1ns/1ps

module llc_lookup_top (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                wb_cyc,
    input  logic                                wb_stb,
    input  logic                                wb_we,
    input  logic                                wb_adr,
    input  logic [llc_pkg::llc_bus_data_bits-1:0] wb_dat_w,
    output logic [llc_pkg::llc_bus_data_bits-1:0] wb_dat_r,
    output logic                                wb_ack
);

    logic                  rd_en;
    llc_pkg::llc_set_t     rd_set;
    llc_pkg::llc_set_buf_t set_buf;
    logic                  lookup_en;
    llc_pkg::llc_way_t     way;
    logic                  evict;
    logic                  wr_en;
    llc_pkg::llc_set_t     wr_set;
    llc_pkg::llc_way_t     wr_way;
    llc_pkg::llc_tag_t     wr_tag;
    llc_pkg::llc_state_t   wr_state;
    logic                  ptr_en;
    llc_pkg::llc_way_t     ptr_next;

    llc_lookup_ctrl u_llc_lookup_ctrl (
        .clk       (clk),
        .rst       (rst),
        .wb_cyc    (wb_cyc),
        .wb_stb    (wb_stb),
        .wb_we     (wb_we),
        .wb_adr    (wb_adr),
        .wb_dat_w  (wb_dat_w),
        .wb_dat_r  (wb_dat_r),
        .wb_ack    (wb_ack),
        .rd_en     (rd_en),
        .rd_set    (rd_set),
        .set_buf   (set_buf),
        .lookup_en (lookup_en),
        .way       (way),
        .evict     (evict),
        .wr_en     (wr_en),
        .wr_set    (wr_set),
        .wr_way    (wr_way),
        .wr_tag    (wr_tag),
        .wr_state  (wr_state),
        .ptr_en    (ptr_en),
        .ptr_next  (ptr_next)
    );

    llc_tag_store u_llc_tag_store (
        .clk      (clk),
        .rst      (rst),
        .rd_en    (rd_en),
        .rd_set   (rd_set),
        .set_buf  (set_buf),
        .wr_en    (wr_en),
        .wr_set   (wr_set),
        .wr_way   (wr_way),
        .wr_tag   (wr_tag),
        .wr_state (wr_state),
        .ptr_en   (ptr_en),
        .ptr_next (ptr_next)
    );

    // lookup compares against the tag of the request being served
    llc_lookup_way u_llc_lookup_way (
        .clk       (clk),
        .rst       (rst),
        .tag       (wr_tag),
        .set_buf   (set_buf),
        .lookup_en (lookup_en),
        .way       (way),
        .way_next  (),
        .evict     (evict)
    );

endmodule

// ==== test/llc_lookup_model.svh ====
`ifndef llc_lookup_model_svh
`define llc_lookup_model_svh

// reference copy of the directory arrays
llc_pkg::llc_tag_t   m_tag   [llc_pkg::llc_sets][llc_pkg::llc_ways];
llc_pkg::llc_state_t m_state [llc_pkg::llc_sets][llc_pkg::llc_ways];
int                  m_ptr   [llc_pkg::llc_sets];

localparam int ack_timeout = 50;

task automatic model_reset();
    for (int s = 0; s < llc_pkg::llc_sets; s++) begin
        m_ptr[s] = 0;
        for (int w = 0; w < llc_pkg::llc_ways; w++) begin
            m_tag[s][w]   = '0;
            m_state[s][w] = llc_pkg::INVALID;
        end
    end
endtask

// hit, then lowest empty, then VALID, non-SD and pointer way scanning from the pointer
function automatic llc_pkg::llc_result_t model_lookup(input int set, input llc_pkg::llc_tag_t tag,
                                                      input llc_pkg::llc_state_t new_state);
    llc_pkg::llc_result_t res;
    int way;
    int w;
    bit found;
    bit hit;
    bit evict;
    found = 0;
    hit   = 0;
    evict = 0;
    way   = m_ptr[set];
    for (int i = 0; i < llc_pkg::llc_ways; i++) begin
        if (!found && m_state[set][i] != llc_pkg::INVALID && m_tag[set][i] == tag) begin
            way   = i;
            found = 1;
            hit   = 1;
        end
    end
    for (int i = 0; i < llc_pkg::llc_ways; i++) begin
        if (!found && m_state[set][i] == llc_pkg::INVALID) begin
            way   = i;
            found = 1;
        end
    end
    evict = !found;
    for (int k = 0; k < llc_pkg::llc_ways; k++) begin
        w = (m_ptr[set] + k) % llc_pkg::llc_ways;
        if (!found && m_state[set][w] == llc_pkg::VALID) begin
            way   = w;
            found = 1;
        end
    end
    for (int k = 0; k < llc_pkg::llc_ways; k++) begin
        w = (m_ptr[set] + k) % llc_pkg::llc_ways;
        if (!found && m_state[set][w] != llc_pkg::SD) begin
            way   = w;
            found = 1;
        end
    end
    res.hit       = hit;
    res.evict     = evict;
    res.way       = llc_pkg::llc_way_t'(way);
    res.old_tag   = m_tag[set][way];
    res.old_state = m_state[set][way];
    m_tag[set][way]   = tag;
    m_state[set][way] = new_state;
    if (evict) begin
        m_ptr[set] = (way + 1) % llc_pkg::llc_ways;
    end
    return res;
endfunction

// cycles counts the clock edges from the one that samples the strobe to the ack cycle
task automatic bus_write(input logic adr, input logic [31:0] data, output int cycles);
    logic got_ack;
    got_ack = 1'b0;
    cycles  = 0;
    @(posedge clk);
    #2;
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = 1'b1;
    wb_adr   = adr;
    wb_dat_w = data;
    while (!got_ack && cycles < ack_timeout) begin
        @(negedge clk);
        got_ack = wb_ack;
        if (!got_ack) begin
            cycles++;
        end
    end
    if (!got_ack) begin
        $display("bus write to address %0d got no ack within %0d cycles", adr, ack_timeout);
        check_errors++;
        finish_run();
    end else begin
        @(posedge clk);
        #2;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    end
endtask

task automatic bus_read(input logic adr, output logic [31:0] data, output int cycles);
    logic got_ack;
    got_ack = 1'b0;
    cycles  = 0;
    data    = '0;
    @(posedge clk);
    #2;
    wb_cyc = 1'b1;
    wb_stb = 1'b1;
    wb_we  = 1'b0;
    wb_adr = adr;
    while (!got_ack && cycles < ack_timeout) begin
        @(negedge clk);
        got_ack = wb_ack;
        data    = wb_dat_r;
        if (!got_ack) begin
            cycles++;
        end
    end
    if (!got_ack) begin
        $display("bus read from address %0d got no ack within %0d cycles", adr, ack_timeout);
        check_errors++;
        finish_run();
    end else begin
        @(posedge clk);
        #2;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
    end
endtask

`endif

// ==== test/llc_lookup_tb.sv ====
`timescale 1ns/1ps

module llc_lookup_tb;

    localparam int req_bits = $bits(llc_pkg::llc_req_t);
    localparam int res_bits = $bits(llc_pkg::llc_result_t);

    logic        clk;
    logic        rst;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    logic        wb_adr;
    logic [31:0] wb_dat_w;
    logic [31:0] wb_dat_r;
    logic        wb_ack;

    int check_errors;
    int errors_at_start;
    int tests_passed;
    int tests_failed;
    int test_num;

    `include "llc_lookup_model.svh"

    llc_lookup_top u_llc_lookup_top (
        .clk      (clk),
        .rst      (rst),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic check_value(input string what, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) else begin
            $display("[ERROR] %0t: %s is %h, expected %h", $time, what, got, exp);
            check_errors++;
        end
    endtask

    task automatic end_test(input string name);
        test_num++;
        if (check_errors == errors_at_start) begin
            tests_passed++;
            $display("test %0d (%s) passed", test_num, name);
        end else begin
            tests_failed++;
            $display("test %0d (%s) FAILED with %0d errors", test_num, name,
                     check_errors - errors_at_start);
        end
        errors_at_start = check_errors;
    endtask

    task automatic finish_run();
        $display("tests passed: %0d, tests failed: %0d, failed checks: %0d",
                 tests_passed, tests_failed, check_errors);
        if (check_errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    endtask

    // one request write plus a result read, both checked against the model
    task automatic run_lookup(input int set, input llc_pkg::llc_tag_t tag,
                              input llc_pkg::llc_state_t new_state,
                              output llc_pkg::llc_result_t res);
        llc_pkg::llc_req_t    req;
        llc_pkg::llc_result_t exp;
        logic [31:0]          wdata;
        logic [31:0]          rdata;
        logic [31:0]          exp_word;
        int                   cycles;
        req.set       = llc_pkg::llc_set_t'(set);
        req.tag       = tag;
        req.new_state = new_state;
        wdata         = '0;
        wdata[req_bits-1:0] = req;
        exp           = model_lookup(set, tag, new_state);
        exp_word      = '0;
        exp_word[res_bits-1:0] = exp;
        bus_write(llc_pkg::llc_addr_req, wdata, cycles);
        check_value("request ack latency", cycles, 4);
        bus_read(llc_pkg::llc_addr_result, rdata, cycles);
        check_value("result read ack latency", cycles, 1);
        check_value("result word", rdata, exp_word);
        res = llc_pkg::llc_result_t'(rdata[res_bits-1:0]);
    endtask

    llc_pkg::llc_result_t res;
    llc_pkg::llc_tag_t    tags [llc_pkg::llc_ways];
    logic [31:0]          rdata;
    int                   cycles;

    initial begin
        void'($urandom(87));
        check_errors    = 0;
        errors_at_start = 0;
        tests_passed    = 0;
        tests_failed    = 0;
        test_num        = 0;
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_adr   = 1'b0;
        wb_dat_w = '0;
        rst      = 1'b0;
        model_reset();
        repeat (2) @(posedge clk);
        #2;
        rst = 1'b1;

        bus_read(llc_pkg::llc_addr_result, rdata, cycles);
        check_value("result after reset", rdata, 0);
        run_lookup(0, llc_pkg::llc_tag_t'($urandom), llc_pkg::VALID, res);
        check_value("first request way", res.way, 0);
        check_value("first request hit/evict", {res.hit, res.evict}, 0);
        end_test("reset and first request");

        // tags kept apart so fills never hit each other
        for (int i = 0; i < llc_pkg::llc_ways; i++) begin
            tags[i] = llc_pkg::llc_tag_t'(i * 32 + $urandom % 32);
            run_lookup(1, tags[i], llc_pkg::VALID, res);
            check_value("fill way", res.way, i);
        end
        for (int i = 0; i < llc_pkg::llc_ways; i++) begin
            run_lookup(1, tags[i], llc_pkg::VALID, res);
            check_value("repeat tag way", res.way, i);
            check_value("repeat tag hit/evict", {res.hit, res.evict}, 2'b10);
        end
        // the result register now holds a hit, so a zero here comes from the address decode
        bus_read(llc_pkg::llc_addr_req, rdata, cycles);
        check_value("read of request address", rdata, 0);
        end_test("fills and hits");

        for (int i = 0; i < llc_pkg::llc_ways; i++) begin
            tags[i] = llc_pkg::llc_tag_t'(i * 32 + $urandom % 32);
            run_lookup(2, tags[i], llc_pkg::VALID, res);
        end
        run_lookup(2, llc_pkg::llc_tag_t'(128 + $urandom % 64), llc_pkg::VALID, res);
        check_value("first victim way", res.way, 0);
        check_value("first victim old tag", res.old_tag, tags[0]);
        run_lookup(2, llc_pkg::llc_tag_t'(192 + $urandom % 64), llc_pkg::VALID, res);
        check_value("second victim way", res.way, 1);
        check_value("second victim evict", res.evict, 1);
        end_test("eviction pointer");

        run_lookup(3, 8'h10, llc_pkg::SD, res);
        run_lookup(3, 8'h11, llc_pkg::SHARED, res);
        run_lookup(3, 8'h12, llc_pkg::SD, res);
        run_lookup(3, 8'h13, llc_pkg::VALID, res);
        run_lookup(3, 8'h90, llc_pkg::SHARED, res);
        check_value("valid victim way", res.way, 3);
        run_lookup(3, 8'h91, llc_pkg::SD, res);
        check_value("shared victim way", res.way, 1);
        end_test("SD skipped");

        for (int i = 0; i < llc_pkg::llc_ways; i++) begin
            tags[i] = llc_pkg::llc_tag_t'(i * 32 + $urandom % 32);
            run_lookup(4, tags[i], llc_pkg::SD, res);
        end
        run_lookup(4, llc_pkg::llc_tag_t'(128 + $urandom % 64), llc_pkg::SD, res);
        check_value("all SD victim way", res.way, 0);
        check_value("all SD evict", res.evict, 1);
        run_lookup(4, tags[2], llc_pkg::INVALID, res);
        run_lookup(4, llc_pkg::llc_tag_t'(192 + $urandom % 64), llc_pkg::VALID, res);
        check_value("invalidated way reused", res.way, 2);
        check_value("invalidated way evict", res.evict, 0);
        end_test("all SD and invalidate");

        // small tag pool so hits, fills and evictions all occur
        for (int n = 0; n < 40; n++) begin
            run_lookup($urandom % llc_pkg::llc_sets, llc_pkg::llc_tag_t'($urandom % 6),
                       llc_pkg::llc_state_t'($urandom % 4), res);
        end
        end_test("random requests");

        finish_run();
    end

endmodule

// ==== sources.f ====
+incdir+test
logic/llc_pkg.sv
logic/llc_tag_store.sv
logic/llc_lookup_way.sv
logic/llc_lookup_ctrl.sv
logic/llc_lookup_top.sv
test/llc_lookup_tb.sv

// ==== Bender.yml ====
package:
  name: llc_lookup

sources:
  - logic/llc_pkg.sv
  - logic/llc_tag_store.sv
  - logic/llc_lookup_way.sv
  - logic/llc_lookup_ctrl.sv
  - logic/llc_lookup_top.sv
  - target: test
    include_dirs:
      - test
    files:
      - test/llc_lookup_tb.sv
